//--- rtl/netpad_pkg.sv
package netpad_pkg;

  // pad buttons in shift order, a comes out of the pad first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_s;

  // report byte, seen as a raw byte or as named buttons
  typedef union packed {
    logic [7:0]   raw;
    pad_buttons_s btn;
  } pad_report_u;

  // one byte on its way to the serializer
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_byte_s;

  // preamble and start of frame delimiter
  localparam int         PREAMBLE_BYTES = 7;
  localparam logic [7:0] PREAMBLE_BYTE  = 8'h55;
  localparam logic [7:0] SFD_BYTE       = 8'hD5;

  // frame layout in bytes
  localparam int ETH_HDR_BYTES = 14;
  localparam int IP_HDR_BYTES  = 20;
  localparam int UDP_HDR_BYTES = 8;
  localparam int HDR_BYTES     = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;
  // report, sequence, then zero fill up to the 60 byte minimum
  localparam int PAYLOAD_BYTES = 18;
  localparam int DATA_BYTES    = HDR_BYTES + PAYLOAD_BYTES;
  localparam int FCS_BYTES     = 4;
  localparam int GAP_BYTES     = 12;

  // protocol fields
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
  localparam logic [7:0]  IP_TTL         = 8'd64;

  // addresses
  localparam logic [47:0] BCAST_MAC = 48'hFF_FF_FF_FF_FF_FF;
  localparam logic [31:0] BCAST_IP  = 32'hFF_FF_FF_FF;
  localparam logic [31:0] SRC_IP    = {8'd10, 8'd0, 8'd0, 8'd2};

  // ethernet crc-32, lsb-first form
  localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;
  localparam logic [31:0] CRC_RESIDUE_INIT   = 32'hFFFF_FFFF;

  // byte index within a phase, counts past 60
  localparam int BYTE_IDX_W = 6;

endpackage

//--- rtl/pad_poller.sv
`timescale 1ns/1ps

module pad_poller
  import netpad_pkg::*;
#(
  parameter int POLL_DIV = 500
) (
  input  logic        eth_refclk,
  input  logic        sys_rst,
  input  logic        data,
  output logic        latch,
  output logic        pulse,
  output pad_report_u report,
  output logic        report_valid,
  input  logic        report_ready
);

  localparam int DIV_W     = (POLL_DIV > 1) ? $clog2(POLL_DIV) : 1;
  localparam int HALF_DIV  = POLL_DIV / 2;
  localparam int BIT_TIMES = 18;
  localparam int PULSES    = 7;

  logic [DIV_W-1:0] div_cnt;
  logic [4:0]       bit_cnt;
  logic             sample;
  logic [2:0]       samp_idx;
  logic             poll_done;
  logic             take_poll;
  pad_report_u      cur;
  logic [7:0]       last_sent;
  logic [7:0]       ref_byte;

  // bit-time divider and position within the poll
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (div_cnt == DIV_W'(POLL_DIV - 1)) begin
      div_cnt <= '0;
      bit_cnt <= (bit_cnt == 5'(BIT_TIMES - 1)) ? 5'd0 : bit_cnt + 5'd1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // latch in bit time 0
  // pulses in the second half of bit times 1..7
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      latch <= 1'b0;
      pulse <= 1'b0;
    end else begin
      latch <= (bit_cnt == 5'd0);
      pulse <= (bit_cnt >= 5'd1) && (bit_cnt <= 5'(PULSES)) &&
               (div_cnt >= DIV_W'(HALF_DIV));
    end
  end

  // every falling edge of latch or pulse lands on div_cnt == 0
  // bit_cnt is one ahead of the button index there
  assign sample   = (div_cnt == '0) && (bit_cnt >= 5'd1) && (bit_cnt <= 5'(PULSES + 1));
  assign samp_idx = 3'(bit_cnt - 5'd1);

  // pad drives low for pressed
  always_ff @(posedge eth_refclk) begin
    if (sample) begin
      case (samp_idx)
        3'd0: cur.btn.a      <= ~data;
        3'd1: cur.btn.b      <= ~data;
        3'd2: cur.btn.select <= ~data;
        3'd3: cur.btn.start  <= ~data;
        3'd4: cur.btn.up     <= ~data;
        3'd5: cur.btn.down   <= ~data;
        3'd6: cur.btn.left   <= ~data;
        default: cur.btn.right <= ~data;
      endcase
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      poll_done <= 1'b0;
    end else begin
      poll_done <= sample && (bit_cnt == 5'(PULSES + 1));
    end
  end

  // compare against what the sequencer has, counting a transfer this cycle
  assign ref_byte  = (report_valid && report_ready) ? report.raw : last_sent;
  assign take_poll = poll_done && (cur.raw != ref_byte);

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      report_valid <= 1'b0;
      last_sent    <= 8'h00;
    end else begin
      if (report_valid && report_ready) begin
        report_valid <= 1'b0;
        last_sent    <= report.raw;
      end
      if (take_poll) begin
        report_valid <= 1'b1;
      end
    end
  end

  // a newer change replaces one still waiting
  always_ff @(posedge eth_refclk) begin
    if (take_poll) begin
      report <= cur;
    end
  end

  a_no_overlap: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    !(latch && pulse));

endmodule

//--- rtl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
  import netpad_pkg::*;
(
  input  logic                  eth_refclk,
  input  logic                  sys_rst,
  input  pad_report_u           report,
  input  logic                  report_valid,
  output logic                  report_ready,
  output logic                  frame_start,
  output logic [BYTE_IDX_W-1:0] field_idx,
  input  logic [7:0]            field_byte,
  output logic                  crc_clear,
  output logic                  crc_en,
  output logic [7:0]            crc_byte,
  input  logic [31:0]           fcs,
  output tx_byte_s              tx,
  output logic                  tx_valid,
  input  logic                  tx_ready
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_PRE,
    PH_DATA,
    PH_FCS,
    PH_GAP
  } phase_e;

  // gap counted from the last handoff, so the last byte still on the wire
  // adds one byte time before the 12 idle ones
  localparam int GAP_CYCLES = (GAP_BYTES + 1) * 4;

  phase_e                phase;
  logic [BYTE_IDX_W-1:0] cnt;
  logic                  xfer;
  logic [7:0]            fcs_byte;

  assign xfer         = tx_valid && tx_ready;
  assign report_ready = (phase == PH_IDLE);
  assign frame_start  = report_valid && report_ready;

  // crc restarts with each frame, sees data bytes as they leave
  assign crc_clear = frame_start;
  assign crc_en    = xfer && (phase == PH_DATA);
  assign crc_byte  = tx.data;

  // index of the byte to load next
  // outside the data phase the next data byte is always byte 0
  assign field_idx = ((phase == PH_DATA) && (cnt != BYTE_IDX_W'(DATA_BYTES - 1))) ?
                     cnt + 1'b1 : '0;

  // fcs goes out low byte first
  assign fcs_byte = 8'(fcs >> {cnt[1:0], 3'b000});

  // cnt is the index of the byte now held in tx
  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      phase    <= PH_IDLE;
      cnt      <= '0;
      tx       <= '0;
      tx_valid <= 1'b0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (frame_start) begin
            phase    <= PH_PRE;
            cnt      <= '0;
            tx.data  <= PREAMBLE_BYTE;
            tx.last  <= 1'b0;
            tx_valid <= 1'b1;
          end
        end
        PH_PRE: begin
          if (xfer) begin
            if (cnt == BYTE_IDX_W'(PREAMBLE_BYTES)) begin
              // sfd is gone, first header byte next
              phase   <= PH_DATA;
              cnt     <= '0;
              tx.data <= field_byte;
            end else begin
              cnt     <= cnt + 1'b1;
              tx.data <= (cnt == BYTE_IDX_W'(PREAMBLE_BYTES - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            end
          end
        end
        PH_DATA: begin
          if (xfer) begin
            if (cnt == BYTE_IDX_W'(DATA_BYTES - 1)) begin
              // one empty cycle lets the crc take in the last byte
              phase    <= PH_FCS;
              cnt      <= '0;
              tx_valid <= 1'b0;
            end else begin
              cnt     <= cnt + 1'b1;
              tx.data <= field_byte;
            end
          end
        end
        PH_FCS: begin
          if (!tx_valid) begin
            tx_valid <= 1'b1;
            tx.data  <= fcs_byte;
            tx.last  <= (cnt == BYTE_IDX_W'(FCS_BYTES - 1));
          end else if (xfer) begin
            // serializer needs 4 cycles per byte, room to reload
            tx_valid <= 1'b0;
            if (cnt == BYTE_IDX_W'(FCS_BYTES - 1)) begin
              phase <= PH_GAP;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        PH_GAP: begin
          if (cnt == BYTE_IDX_W'(GAP_CYCLES - 1)) begin
            phase <= PH_IDLE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  a_tx_hold: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx));

  // a new report only lands when no byte is pending
  a_ready_idle: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    report_ready |-> (phase == PH_IDLE) && !tx_valid);

endmodule

//--- rtl/frame_fields.sv
`timescale 1ns/1ps

module frame_fields
  import netpad_pkg::*;
#(
  parameter logic [47:0] SRC_MAC  = 48'h42_04_20_42_04_20,
  parameter logic [15:0] UDP_PORT = 16'd42069
) (
  input  logic                  eth_refclk,
  input  logic                  sys_rst,
  input  logic                  frame_start,
  input  pad_report_u           report,
  input  logic [BYTE_IDX_W-1:0] field_idx,
  output logic [7:0]            field_byte
);

  localparam logic [15:0] IP_VER_TOS = 16'h4500;
  localparam logic [15:0] IP_FLAGS   = 16'h4000;
  localparam logic [15:0] IP_LEN     = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAYLOAD_BYTES);
  localparam logic [15:0] UDP_LEN    = 16'(UDP_HDR_BYTES + PAYLOAD_BYTES);
  // header plus report and sequence, the rest reads as zero
  localparam int MAP_BYTES = HDR_BYTES + 2;

  logic [7:0]             seq;
  logic [7:0]             seq_q;
  pad_report_u            rep_q;
  logic [15:0]            csum_q;
  logic [MAP_BYTES*8-1:0] map;

  // ones' complement sum over the header words, checksum word as zero
  function automatic logic [15:0] ip_checksum(input logic [15:0] ident);
    logic [31:0] sum;
    sum = IP_VER_TOS + IP_LEN + ident + IP_FLAGS + {IP_TTL, IP_PROTO_UDP} +
          SRC_IP[31:16] + SRC_IP[15:0] + BCAST_IP[31:16] + BCAST_IP[15:0];
    // fold carries twice
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    return ~sum[15:0];
  endfunction

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      seq <= 8'h00;
    end else if (frame_start) begin
      seq <= seq + 8'h01;
    end
  end

  // per-frame snapshot, checksum follows the identification
  always_ff @(posedge eth_refclk) begin
    if (frame_start) begin
      rep_q  <= report;
      seq_q  <= seq;
      csum_q <= ip_checksum({8'h00, seq});
    end
  end

  // network order, byte 0 at the top
  assign map = {
    BCAST_MAC,
    SRC_MAC,
    ETHERTYPE_IPV4,
    // ipv4
    IP_VER_TOS,
    IP_LEN,
    {8'h00, seq_q},
    IP_FLAGS,
    IP_TTL,
    IP_PROTO_UDP,
    csum_q,
    SRC_IP,
    BCAST_IP,
    // udp, no checksum
    UDP_PORT,
    UDP_PORT,
    UDP_LEN,
    16'h0000,
    // payload head
    rep_q.raw,
    seq_q
  };

  always_comb begin
    if (field_idx < BYTE_IDX_W'(MAP_BYTES)) begin
      field_byte = map[(MAP_BYTES - 1 - field_idx) * 8 +: 8];
    end else begin
      field_byte = 8'h00;
    end
  end

endmodule

//--- rtl/crc32_engine.sv
`timescale 1ns/1ps

module crc32_engine
  import netpad_pkg::*;
(
  input  logic        eth_refclk,
  input  logic        sys_rst,
  input  logic        crc_clear,
  input  logic        crc_en,
  input  logic [7:0]  crc_byte,
  output logic [31:0] fcs
);

  logic [31:0] residue;

  // one byte, lsb first, as the bits hit the wire
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h000000, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY_REFLECTED) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge eth_refclk) begin
    if (sys_rst || crc_clear) begin
      residue <= CRC_RESIDUE_INIT;
    end else if (crc_en) begin
      residue <= crc_step(residue, crc_byte);
    end
  end

  // reflected register is already in wire order
  // bit 0 leaves first, low byte first
  assign fcs = ~residue;

endmodule

//--- rtl/rmii_tx.sv
`timescale 1ns/1ps

module rmii_tx
  import netpad_pkg::*;
(
  input  logic       eth_refclk,
  input  logic       sys_rst,
  input  tx_byte_s   tx,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic [1:0] eth_txd,
  output logic       eth_txen
);

  // dibits of the current byte not yet on the wire
  logic [5:0] shreg;
  // dibits sent of the current byte, wraps to 0 after the fourth
  logic [1:0] dib_cnt;
  logic       last_q;
  logic       xfer;

  // idle, or at a byte boundary inside a frame that has more to come
  assign tx_ready = !eth_txen || ((dib_cnt == 2'd0) && !last_q);
  assign xfer     = tx_valid && tx_ready;

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      eth_txen <= 1'b0;
      eth_txd  <= 2'b00;
      dib_cnt  <= 2'd0;
      last_q   <= 1'b0;
    end else if (xfer) begin
      // first dibit goes out with the handoff
      eth_txen <= 1'b1;
      eth_txd  <= tx.data[1:0];
      dib_cnt  <= 2'd1;
      last_q   <= tx.last;
    end else if (eth_txen && (dib_cnt != 2'd0)) begin
      eth_txd <= shreg[1:0];
      dib_cnt <= dib_cnt + 2'd1;
    end else begin
      // end of frame after the last byte's fourth dibit
      eth_txen <= 1'b0;
      eth_txd  <= 2'b00;
      last_q   <= 1'b0;
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (xfer) begin
      shreg <= tx.data[7:2];
    end else begin
      shreg <= {2'b00, shreg[5:2]};
    end
  end

  // no underrun inside a frame
  a_no_underrun: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    eth_txen && (dib_cnt == 2'd0) && !last_q |-> tx_valid);

endmodule

//--- rtl/netpad_top.sv
`timescale 1ns/1ps

module netpad_top
  import netpad_pkg::*;
#(
  parameter logic [47:0] SRC_MAC  = 48'h42_04_20_42_04_20,
  parameter logic [15:0] UDP_PORT = 16'd42069,
  parameter int          POLL_DIV = 500
) (
  input  logic       eth_refclk,
  input  logic       sys_rst,
  input  logic       data,
  output logic       latch,
  output logic       pulse,
  output logic [1:0] eth_txd,
  output logic       eth_txen,
  output logic       eth_rstn
);

  // report link
  pad_report_u           report;
  logic                  report_valid;
  logic                  report_ready;
  // field fetch
  logic                  frame_start;
  logic [BYTE_IDX_W-1:0] field_idx;
  logic [7:0]            field_byte;
  // crc path
  logic                  crc_clear;
  logic                  crc_en;
  logic [7:0]            crc_byte;
  logic [31:0]           fcs;
  // byte link
  tx_byte_s              tx;
  logic                  tx_valid;
  logic                  tx_ready;

  // phy held in reset with the design
  assign eth_rstn = ~sys_rst;

  pad_poller #(
    .POLL_DIV(POLL_DIV)
  ) u_poller (
    .eth_refclk  (eth_refclk),
    .sys_rst     (sys_rst),
    .data        (data),
    .latch       (latch),
    .pulse       (pulse),
    .report      (report),
    .report_valid(report_valid),
    .report_ready(report_ready)
  );

  frame_sequencer u_sequencer (
    .eth_refclk  (eth_refclk),
    .sys_rst     (sys_rst),
    .report      (report),
    .report_valid(report_valid),
    .report_ready(report_ready),
    .frame_start (frame_start),
    .field_idx   (field_idx),
    .field_byte  (field_byte),
    .crc_clear   (crc_clear),
    .crc_en      (crc_en),
    .crc_byte    (crc_byte),
    .fcs         (fcs),
    .tx          (tx),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready)
  );

  frame_fields #(
    .SRC_MAC (SRC_MAC),
    .UDP_PORT(UDP_PORT)
  ) u_fields (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .frame_start(frame_start),
    .report     (report),
    .field_idx  (field_idx),
    .field_byte (field_byte)
  );

  crc32_engine u_crc (
    .eth_refclk(eth_refclk),
    .sys_rst   (sys_rst),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_byte  (crc_byte),
    .fcs       (fcs)
  );

  rmii_tx u_rmii (
    .eth_refclk(eth_refclk),
    .sys_rst   (sys_rst),
    .tx        (tx),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .eth_txd   (eth_txd),
    .eth_txen  (eth_txen)
  );

endmodule

//--- testbench/netpad_tb.sv
`timescale 1ns/1ps

module netpad_tb;

  localparam logic [47:0] SRC_MAC     = 48'h42_04_20_42_04_20;
  localparam logic [15:0] UDP_PORT    = 16'd42069;
  localparam int          POLL_DIV    = 8;
  localparam int          POLL_CYCLES = 18 * POLL_DIV;
  localparam int          CHANGES     = 8;
  localparam int          HOLD_POLLS  = 3;
  // each change needs a few polls plus one frame and its gap
  localparam int          TIMEOUT_CYCLES = CHANGES * (3 * POLL_CYCLES + 336) * 2;

  logic       eth_refclk;
  logic       sys_rst;
  logic       data;
  logic       latch;
  logic       pulse;
  logic [1:0] eth_txd;
  logic       eth_txen;
  logic       eth_rstn;

  int         errors;
  int         cycles;
  int         changes;
  int         frame_cnt;
  logic [31:0] lfsr;
  logic [7:0] exp_q[$];
  logic [7:0] exp_data [0:59];

  // pad model state
  logic [7:0] pad_byte;
  logic [7:0] pad_sh;
  logic       latch_q;
  logic       pulse_q;
  logic       last_repeat;
  int         pulse_cnt;
  int         latch_len;
  int         polls;
  int         polls_left;

  // rmii capture state
  logic [7:0] rx_bytes [0:79];
  logic [7:0] cur_b;
  logic       txen_q;
  int         dib;
  int         nbytes;
  int         on_cnt;
  int         idle_cnt;

  netpad_top #(
    .SRC_MAC (SRC_MAC),
    .UDP_PORT(UDP_PORT),
    .POLL_DIV(POLL_DIV)
  ) u_dut (
    .eth_refclk(eth_refclk),
    .sys_rst   (sys_rst),
    .data      (data),
    .latch     (latch),
    .pulse     (pulse),
    .eth_txd   (eth_txd),
    .eth_txen  (eth_txen),
    .eth_rstn  (eth_rstn)
  );

  always #20 eth_refclk = ~eth_refclk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // galois form, taps 32 22 2 1
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("Fail %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  // ones' complement sum of the ip header words, checksum word skipped
  function automatic logic [15:0] ref_ip_checksum();
    logic [31:0] sum;
    sum = 32'h0;
    for (int i = 14; i < 34; i += 2) begin
      if (i != 24) begin
        sum = sum + {16'h0, exp_data[i], exp_data[i + 1]};
      end
    end
    while (sum[31:16] != 16'h0) begin
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    return ~sum[15:0];
  endfunction

  // msb-first crc-32 fed lsb-first bits, then reflected into wire order
  function automatic logic [31:0] ref_fcs();
    logic [31:0] c;
    logic [31:0] r;
    logic        fb;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < 60; i++) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[31] ^ exp_data[i][b];
        c  = {c[30:0], 1'b0};
        if (fb) c = c ^ 32'h04C1_1DB7;
      end
    end
    c = ~c;
    for (int b = 0; b < 32; b++) r[b] = c[31 - b];
    return r;
  endfunction

  // new pad byte every few polls, sometimes the same one again
  task automatic next_pad_byte();
    logic [7:0] r;
    if ((polls_left == 0) && (changes < CHANGES)) begin
      draw_bits(2, r);
      if ((r[1:0] == 2'b00) && !last_repeat) begin
        last_repeat = 1'b1;
      end else begin
        draw_bits(8, r);
        if (r == pad_byte) r = r ^ 8'h01;
        pad_byte = r;
        exp_q.push_back(r);
        changes++;
        last_repeat = 1'b0;
      end
      polls_left = HOLD_POLLS;
    end
    if (polls_left > 0) polls_left--;
  endtask

  // expected 60 data bytes, from the frame rules
  task automatic build_expected(input logic [7:0] rep, input logic [7:0] seq);
    logic [15:0] csum;
    for (int i = 0; i < 60; i++) exp_data[i] = 8'h00;
    for (int i = 0; i < 6; i++) begin
      exp_data[i]     = 8'hFF;
      exp_data[6 + i] = SRC_MAC[47 - 8 * i -: 8];
    end
    exp_data[12] = 8'h08;
    exp_data[14] = 8'h45;
    exp_data[17] = 8'd46;
    exp_data[19] = seq;
    exp_data[20] = 8'h40;
    exp_data[22] = 8'd64;
    exp_data[23] = 8'd17;
    exp_data[26] = 8'd10;
    exp_data[29] = 8'd2;
    for (int i = 30; i < 34; i++) exp_data[i] = 8'hFF;
    exp_data[34] = UDP_PORT[15:8];
    exp_data[35] = UDP_PORT[7:0];
    exp_data[36] = UDP_PORT[15:8];
    exp_data[37] = UDP_PORT[7:0];
    exp_data[39] = 8'd26;
    exp_data[42] = rep;
    exp_data[43] = seq;
    csum = ref_ip_checksum();
    exp_data[24] = csum[15:8];
    exp_data[25] = csum[7:0];
  endtask

  task automatic check_frame();
    logic [7:0]  rep;
    logic [31:0] fcs;
    string       tag;
    tag = $sformatf("frame %0d", frame_cnt);
    compare_value({tag, " txen cycles"}, 288, on_cnt);
    compare_value({tag, " byte count"}, 72, nbytes);
    if (exp_q.size() == 0) begin
      errors++;
      $display("frame %0d was sent although the pad byte did not change", frame_cnt);
    end else begin
      rep = exp_q.pop_front();
      for (int i = 0; i < 7; i++) begin
        compare_value($sformatf("%s preamble %0d", tag, i), 8'h55, rx_bytes[i]);
      end
      compare_value({tag, " sfd"}, 8'hD5, rx_bytes[7]);
      build_expected(rep, 8'(frame_cnt));
      compare_value({tag, " ip checksum"}, {exp_data[24], exp_data[25]},
                    {rx_bytes[32], rx_bytes[33]});
      compare_value({tag, " report"}, rep, rx_bytes[50]);
      compare_value({tag, " sequence"}, 8'(frame_cnt), rx_bytes[51]);
      for (int i = 0; i < 60; i++) begin
        compare_value($sformatf("%s data byte %0d", tag, i), exp_data[i], rx_bytes[8 + i]);
      end
      fcs = ref_fcs();
      for (int i = 0; i < 4; i++) begin
        compare_value($sformatf("%s fcs byte %0d", tag, i), fcs[8 * i +: 8], rx_bytes[68 + i]);
      end
    end
    frame_cnt++;
  endtask

  // pad model, shift register loaded on latch, shifted on pulse rise
  always @(posedge eth_refclk) begin
    #2;
    if (!sys_rst) begin
      if (latch && !latch_q) begin
        if (polls > 0) compare_value("pulses per poll", 7, pulse_cnt);
        pulse_cnt = 0;
        latch_len = 0;
        polls++;
        next_pad_byte();
        // pressed reads low
        pad_sh = ~pad_byte;
      end else if (pulse && !pulse_q) begin
        pulse_cnt++;
        pad_sh = {1'b1, pad_sh[7:1]};
      end
      if (latch) latch_len++;
      if (!latch && latch_q) compare_value("latch width", POLL_DIV, latch_len);
      latch_q = latch;
      pulse_q = pulse;
      data    = pad_sh[0];
    end
  end

  // rmii capture at the falling edge, lsb dibit first
  always @(negedge eth_refclk) begin
    if (!sys_rst) begin
      if (eth_txen) begin
        if (!txen_q) begin
          if (frame_cnt > 0 && idle_cnt < 48) begin
            errors++;
            $display("frame %0d started only %0d cycles after the last one", frame_cnt,
                     idle_cnt);
          end
          on_cnt = 0;
          nbytes = 0;
          dib    = 0;
        end
        on_cnt++;
        cur_b = {eth_txd, cur_b[7:2]};
        dib++;
        if (dib == 4) begin
          if (nbytes < 80) rx_bytes[nbytes] = cur_b;
          nbytes++;
          dib = 0;
        end
      end else if (txen_q) begin
        check_frame();
        idle_cnt = 1;
      end else begin
        idle_cnt++;
      end
      txen_q = eth_txen;
    end
  end

  a_no_overlap: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    !(latch && pulse)) else begin
    errors++;
    $display("latch and pulse were high at the same time");
  end

  // outputs quiet right after reset
  a_reset_state: assert property (@(posedge eth_refclk)
    sys_rst |=> !eth_txen && !latch && !pulse && (eth_txd == 2'b00)) else begin
    errors++;
    $display("outputs were not idle after reset");
  end

  a_phy_reset: assert property (@(posedge eth_refclk) eth_rstn == !sys_rst) else begin
    errors++;
    $display("eth_rstn did not follow sys_rst");
  end

  a_txd_idle: assert property (@(posedge eth_refclk) disable iff (sys_rst)
    !eth_txen |-> (eth_txd == 2'b00)) else begin
    errors++;
    $display("eth_txd was not zero while eth_txen was low");
  end

  always @(posedge eth_refclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d frames seen", cycles, frame_cnt,
               CHANGES);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    eth_refclk  = 1'b0;
    sys_rst     = 1'b1;
    data        = 1'b1;
    errors      = 0;
    cycles      = 0;
    changes     = 0;
    frame_cnt   = 0;
    lfsr        = 32'h0ed13255;
    pad_byte    = 8'h00;
    pad_sh      = 8'hFF;
    latch_q     = 1'b0;
    pulse_q     = 1'b0;
    last_repeat = 1'b0;
    pulse_cnt   = 0;
    latch_len   = 0;
    polls       = 0;
    polls_left  = 0;
    cur_b       = 8'h00;
    txen_q      = 1'b0;
    dib         = 0;
    nbytes      = 0;
    on_cnt      = 0;
    idle_cnt    = 0;
    repeat (8) @(posedge eth_refclk);
    #2 sys_rst = 1'b0;
    wait ((changes == CHANGES) && (frame_cnt == CHANGES));
    // pad held steady, no further frame may show up
    repeat (4 * POLL_CYCLES) @(posedge eth_refclk);
    compare_value("frames left unsent", 0, exp_q.size());
    compare_value("frame count", changes, frame_cnt);
    $display("frames %0d, pad changes %0d, errors %0d", frame_cnt, changes, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- flist.f
rtl/netpad_pkg.sv
rtl/pad_poller.sv
rtl/frame_sequencer.sv
rtl/frame_fields.sv
rtl/crc32_engine.sv
rtl/rmii_tx.sv
rtl/netpad_top.sv
testbench/netpad_tb.sv
